// ==== verilog/rob_pkg.sv ====
package rob_pkg;

    localparam int rob_depth = 16;
    localparam int tag_w     = $clog2(rob_depth);
    localparam int reg_w     = 5;
    localparam int data_w    = 32;
    localparam int addr_w    = 32;

    typedef logic [tag_w-1:0]  rob_tag_t;
    typedef logic [reg_w-1:0]  reg_name_t;
    typedef logic [data_w-1:0] data_t;
    typedef logic [addr_w-1:0] addr_t;

    // occupancy runs 0..rob_depth inclusive
    typedef logic [tag_w:0]    rob_cnt_t;

    typedef enum logic [1:0] {
        op_alu    = 2'd0,
        op_load   = 2'd1,
        op_store  = 2'd2,
        op_branch = 2'd3
    } rob_op_e;

    typedef struct packed {
        rob_op_e   op;
        reg_name_t rd;
        logic      pred_taken;
    } alloc_req_t;

    // writeback from execute or load/store buffer
    typedef struct packed {
        rob_tag_t tag;
        data_t    data;
        logic     taken;
        addr_t    target;
    } result_t;

    typedef struct packed {
        rob_op_e   op;
        reg_name_t rd;
        logic      pred_taken;
        logic      done;
        logic      taken;
        data_t     data;
        addr_t     target;
        logic      released;
    } rob_entry_t;

    typedef struct packed {
        reg_name_t rd;
        data_t     data;
        rob_tag_t  tag;
    } commit_t;

endpackage

// ==== verilog/rob_alloc.sv ====
`timescale 1ns/1ps

module rob_alloc
    import rob_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     rdy,
    input  logic     alloc_en,
    input  logic     retire,
    input  logic     squash,
    output rob_tag_t tail,
    output logic     alloc_fire,
    output logic     full
);

    rob_cnt_t count;

    assign full       = (count == rob_cnt_t'(rob_depth));
    assign alloc_fire = alloc_en && rdy && !full;

    // tail wraps on its own at 4 bits
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tail <= '0;
        end else if (squash) begin
            tail <= '0;
        end else if (alloc_fire) begin
            tail <= tail + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count <= '0;
        end else if (squash) begin
            count <= '0;
        end else if (rdy) begin
            case ({alloc_fire, retire})
                2'b10: begin
                    count <= count + 1'b1;
                end
                2'b01: begin
                    count <= count - 1'b1;
                end
                default: begin
                    // both or neither, no change
                    count <= count;
                end
            endcase
        end
    end

endmodule

// ==== verilog/rob_entries.sv ====
`timescale 1ns/1ps

module rob_entries
    import rob_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       rdy,
    input  logic       alloc_fire,
    input  rob_tag_t   tail,
    input  alloc_req_t alloc_req,
    input  logic       ex_en,
    input  result_t    ex_res,
    input  logic       sb_en,
    input  result_t    sb_res,
    input  rob_tag_t   head,
    input  logic       retire,
    input  logic       store_mark,
    input  logic       squash,
    output rob_entry_t head_entry,
    output logic       head_valid
);

    logic [rob_depth-1:0] occupied;
    rob_entry_t           mem [rob_depth];

    rob_entry_t new_entry;
    logic       ex_ok;
    logic       sb_ok;
    logic       same_tag;

    always_comb begin
        new_entry            = '0;
        new_entry.op         = alloc_req.op;
        new_entry.rd         = alloc_req.rd;
        new_entry.pred_taken = alloc_req.pred_taken;
    end

    // a result lands once, and only on a live entry
    assign ex_ok = ex_en && occupied[ex_res.tag] && !mem[ex_res.tag].done;

    assign same_tag = (ex_res.tag == sb_res.tag);

    // execute wins on a tag collision
    assign sb_ok = sb_en && occupied[sb_res.tag] && !mem[sb_res.tag].done
                   && !(ex_ok && same_tag);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            occupied <= '0;
        end else if (squash) begin
            occupied <= '0;
        end else if (rdy) begin
            if (alloc_fire) begin
                occupied[tail] <= 1'b1;
            end
            if (retire) begin
                occupied[head] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rdy) begin
            if (alloc_fire) begin
                mem[tail] <= new_entry;
            end

            if (ex_ok) begin
                mem[ex_res.tag].done   <= 1'b1;
                mem[ex_res.tag].data   <= ex_res.data;
                mem[ex_res.tag].taken  <= ex_res.taken;
                mem[ex_res.tag].target <= ex_res.target;
            end

            // load data or store ack, branch fields untouched
            if (sb_ok) begin
                mem[sb_res.tag].done <= 1'b1;
                mem[sb_res.tag].data <= sb_res.data;
            end

            if (store_mark) begin
                mem[head].released <= 1'b1;
            end
        end
    end

    assign head_entry = mem[head];
    assign head_valid = occupied[head];

endmodule

// ==== verilog/rob_commit.sv ====
`timescale 1ns/1ps

module rob_commit
    import rob_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       rdy,
    input  logic       flush_in,
    input  logic       head_valid,
    input  rob_entry_t head_entry,
    output rob_tag_t   head,
    output logic       retire,
    output logic       squash,
    output logic       store_mark,
    output logic       rf_we,
    output commit_t    rf_wr,
    output logic       store_release,
    output rob_tag_t   store_tag,
    output logic       flush,
    output addr_t      redirect_pc
);

    logic is_store;
    logic is_branch;
    logic mispredict;
    logic flush_q;

    assign is_store  = (head_entry.op == op_store);
    assign is_branch = (head_entry.op == op_branch);

    assign retire     = rdy && head_valid && head_entry.done;
    assign mispredict = retire && is_branch
                        && (head_entry.taken != head_entry.pred_taken);

    // the branch itself still writes its link register
    assign rf_we       = retire && !is_store;
    assign rf_wr.rd    = head_entry.rd;
    assign rf_wr.data  = head_entry.data;
    assign rf_wr.tag   = head;

    // store waits at head until the buffer acks it
    assign store_release = rdy && head_valid && is_store
                           && !head_entry.done && !head_entry.released;
    assign store_mark    = store_release;
    assign store_tag     = head;

    assign squash = rdy && (flush_in || mispredict);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            head <= '0;
        end else if (squash) begin
            head <= '0;
        end else if (retire) begin
            head <= head + 1'b1;
        end
    end

    // pulse holds through a stall, shows once rdy returns
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            flush_q <= 1'b0;
        end else if (rdy) begin
            flush_q <= mispredict;
        end
    end

    always_ff @(posedge clk) begin
        if (mispredict) begin
            redirect_pc <= head_entry.target;
        end
    end

    assign flush = flush_q && rdy;

endmodule

// ==== verilog/rob_top.sv ====
`timescale 1ns/1ps

module rob_top
    import rob_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       rdy,
    input  logic       alloc_en,
    input  alloc_req_t alloc_req,
    input  logic       ex_en,
    input  result_t    ex_res,
    input  logic       sb_en,
    input  result_t    sb_res,
    input  logic       flush_in,
    output logic       full,
    output rob_tag_t   alloc_tag,
    output logic       rf_we,
    output commit_t    rf_wr,
    output logic       store_release,
    output rob_tag_t   store_tag,
    output logic       flush,
    output addr_t      redirect_pc
);

    rob_tag_t   tail;
    rob_tag_t   head;
    logic       alloc_fire;
    logic       retire;
    logic       squash;
    logic       store_mark;
    logic       head_valid;
    rob_entry_t head_entry;

    assign alloc_tag = tail;

    rob_alloc u_alloc (
        .clk        (clk),
        .rst_n      (rst_n),
        .rdy        (rdy),
        .alloc_en   (alloc_en),
        .retire     (retire),
        .squash     (squash),
        .tail       (tail),
        .alloc_fire (alloc_fire),
        .full       (full)
    );

    rob_entries u_entries (
        .clk        (clk),
        .rst_n      (rst_n),
        .rdy        (rdy),
        .alloc_fire (alloc_fire),
        .tail       (tail),
        .alloc_req  (alloc_req),
        .ex_en      (ex_en),
        .ex_res     (ex_res),
        .sb_en      (sb_en),
        .sb_res     (sb_res),
        .head       (head),
        .retire     (retire),
        .store_mark (store_mark),
        .squash     (squash),
        .head_entry (head_entry),
        .head_valid (head_valid)
    );

    rob_commit u_commit (
        .clk           (clk),
        .rst_n         (rst_n),
        .rdy           (rdy),
        .flush_in      (flush_in),
        .head_valid    (head_valid),
        .head_entry    (head_entry),
        .head          (head),
        .retire        (retire),
        .squash        (squash),
        .store_mark    (store_mark),
        .rf_we         (rf_we),
        .rf_wr         (rf_wr),
        .store_release (store_release),
        .store_tag     (store_tag),
        .flush         (flush),
        .redirect_pc   (redirect_pc)
    );

endmodule

// ==== verif/rob_assertions.sv ====
`timescale 1ns/1ps

module rob_assertions (
    input logic clk,
    input logic rst_n,
    input logic rdy,
    input logic rf_we,
    input logic store_release,
    input logic flush
);

    int assert_fails = 0;

    // redirect is a single-cycle pulse
    flush_one_cycle: assert property (
        @(posedge clk) disable iff (!rst_n) flush |=> !flush
    ) else begin
        assert_fails++;
        $error("flush stayed high for more than one cycle");
    end

    // a store retires without a register write
    no_write_with_release: assert property (
        @(posedge clk) disable iff (!rst_n) !(rf_we && store_release)
    ) else begin
        assert_fails++;
        $error("rf_we and store_release were high in the same cycle");
    end

    quiet_during_stall: assert property (
        @(posedge clk) disable iff (!rst_n) !rdy |-> !(rf_we || store_release || flush)
    ) else begin
        assert_fails++;
        $error("a strobe was high while rdy was low");
    end

endmodule

bind rob_top rob_assertions u_assert (
    .clk           (clk),
    .rst_n         (rst_n),
    .rdy           (rdy),
    .rf_we         (rf_we),
    .store_release (store_release),
    .flush         (flush)
);

// ==== verif/rob_tb.sv ====
`timescale 1ns/1ps

module rob_tb
    import rob_pkg::*;
();

    localparam int num_rows       = 10;
    localparam int store_row      = 3;
    localparam int mis_row        = 7;
    localparam int timeout_cycles = (num_rows + rob_depth) * 40 + 200;

    typedef struct packed {
        rob_op_e   op;
        reg_name_t rd;
        logic      pred_taken;
        logic      taken;
        data_t     data;
        addr_t     target;
    } row_t;

    logic       clk;
    logic       rst_n;
    logic       rdy;
    logic       alloc_en;
    alloc_req_t alloc_req;
    logic       ex_en;
    result_t    ex_res;
    logic       sb_en;
    result_t    sb_res;
    logic       flush_in;
    logic       full;
    rob_tag_t   alloc_tag;
    logic       rf_we;
    commit_t    rf_wr;
    logic       store_release;
    rob_tag_t   store_tag;
    logic       flush;
    addr_t      redirect_pc;

    row_t        rows [num_rows];
    commit_t     exp_q [$];
    int          errors;
    int          checks;
    int          store_cnt;
    int          flush_cnt;
    rob_tag_t    last_store_tag;
    addr_t       last_redirect;
    string       test_name;
    logic [31:0] seed;

    rob_top UUT (
        .clk           (clk),
        .rst_n         (rst_n),
        .rdy           (rdy),
        .alloc_en      (alloc_en),
        .alloc_req     (alloc_req),
        .ex_en         (ex_en),
        .ex_res        (ex_res),
        .sb_en         (sb_en),
        .sb_res        (sb_res),
        .flush_in      (flush_in),
        .full          (full),
        .alloc_tag     (alloc_tag),
        .rf_we         (rf_we),
        .rf_wr         (rf_wr),
        .store_release (store_release),
        .store_tag     (store_tag),
        .flush         (flush),
        .redirect_pc   (redirect_pc)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic compare(input string name, input logic [63:0] expected,
                           input logic [63:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    task automatic set_row(input int idx, input rob_op_e op, input int rd, input logic pt,
                           input logic tk, input data_t data, input addr_t target);
        rows[idx].op         = op;
        rows[idx].rd         = reg_name_t'(rd);
        rows[idx].pred_taken = pt;
        rows[idx].taken      = tk;
        rows[idx].data       = data;
        rows[idx].target     = target;
    endtask

    // drive one request, then check the tag it is offered
    task automatic alloc_one(input alloc_req_t req, input rob_tag_t exp_tag);
        @(posedge clk);
        alloc_en  <= 1'b1;
        alloc_req <= req;
        @(negedge clk);
        compare({test_name, " alloc_tag"}, exp_tag, alloc_tag);
    endtask

    task automatic alloc_stop();
        @(posedge clk);
        alloc_en <= 1'b0;
    endtask

    task automatic send_result(input logic use_sb, input rob_tag_t tag, input data_t data,
                               input logic taken, input addr_t target);
        result_t res;
        res.tag    = tag;
        res.data   = data;
        res.taken  = taken;
        res.target = target;
        @(posedge clk);
        ex_en  <= !use_sb;
        sb_en  <= use_sb;
        ex_res <= use_sb ? '0 : res;
        sb_res <= use_sb ? res : '0;
    endtask

    task automatic result_stop();
        @(posedge clk);
        ex_en <= 1'b0;
        sb_en <= 1'b0;
    endtask

    // retire and redirect monitor on the falling edge
    always @(negedge clk) begin
        if (rst_n) begin
            if (rf_we) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("%s: register write for tag %0d when nothing should retire",
                             test_name, rf_wr.tag);
                end else begin
                    compare({test_name, " retire"}, exp_q.pop_front(), rf_wr);
                end
            end
            if (store_release) begin
                store_cnt++;
                last_store_tag = store_tag;
            end
            if (flush) begin
                flush_cnt++;
                last_redirect = redirect_pc;
            end
        end
    end

    initial begin
        repeat (timeout_cycles) @(posedge clk);
        $display("timeout: the run did not finish within %0d clock cycles", timeout_cycles);
        $display("Errors found");
        $finish;
    end

    initial begin
        int         order [$];
        int         j;
        int         tmp;
        int         total;
        row_t       r;
        commit_t    c;
        alloc_req_t req;

        clk       = 1'b0;
        rst_n     = 1'b0;
        rdy       = 1'b1;
        alloc_en  = 1'b0;
        alloc_req = '0;
        ex_en     = 1'b0;
        ex_res    = '0;
        sb_en     = 1'b0;
        sb_res    = '0;
        flush_in  = 1'b0;
        errors    = 0;
        checks    = 0;
        store_cnt = 0;
        flush_cnt = 0;
        seed      = 32'h4ad5_c934;
        test_name = "reset";

        set_row(0, op_alu,    1, 1'b0, 1'b0, 32'h0000_1111, 32'h0);
        set_row(1, op_load,   2, 1'b0, 1'b0, 32'h0000_2222, 32'h0);
        set_row(2, op_alu,    3, 1'b0, 1'b0, 32'h0000_3333, 32'h0);
        set_row(3, op_store,  0, 1'b0, 1'b0, 32'h0,         32'h0);
        set_row(4, op_load,   4, 1'b0, 1'b0, 32'h0000_4444, 32'h0);
        set_row(5, op_branch, 5, 1'b1, 1'b1, 32'h0000_5555, 32'h0000_0800);
        set_row(6, op_alu,    6, 1'b0, 1'b0, 32'h0000_6666, 32'h0);
        set_row(7, op_branch, 7, 1'b0, 1'b1, 32'h0000_7777, 32'h0000_1040);
        set_row(8, op_alu,    8, 1'b0, 1'b0, 32'h0000_8888, 32'h0);
        set_row(9, op_load,   9, 1'b0, 1'b0, 32'h0000_9999, 32'h0);

        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        compare("reset full", 0, full);
        compare("reset rf_we", 0, rf_we);
        compare("reset store_release", 0, store_release);
        compare("reset flush", 0, flush);
        compare("reset alloc_tag", 0, alloc_tag);

        // expected retires stop at the first mispredicted branch
        test_name = "in order retire";
        for (int i = 0; i < num_rows; i++) begin
            if (rows[i].op != op_store) begin
                c.rd   = rows[i].rd;
                c.data = rows[i].data;
                c.tag  = rob_tag_t'(i);
                exp_q.push_back(c);
                if (rows[i].op == op_branch && rows[i].taken != rows[i].pred_taken) begin
                    break;
                end
            end
        end
        for (int i = 0; i < num_rows; i++) begin
            req.op         = rows[i].op;
            req.rd         = rows[i].rd;
            req.pred_taken = rows[i].pred_taken;
            alloc_one(req, rob_tag_t'(i));
        end
        alloc_stop();

        for (int i = 0; i < num_rows; i++) begin
            if (rows[i].op != op_store) begin
                order.push_back(i);
            end
        end
        for (int i = order.size() - 1; i > 0; i--) begin
            seed     = xorshift(seed);
            j        = int'(seed % (i + 1));
            tmp      = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        foreach (order[k]) begin
            r = rows[order[k]];
            send_result(r.op == op_load, rob_tag_t'(order[k]), r.data, r.taken, r.target);
        end
        result_stop();

        test_name = "store";
        wait (store_cnt == 1);
        compare("store tag", store_row, last_store_tag);
        send_result(1'b1, rob_tag_t'(store_row), '0, 1'b0, '0);
        result_stop();

        test_name = "mispredict";
        wait (flush_cnt == 1);
        repeat (4) @(posedge clk);
        @(negedge clk);
        compare("mispredict redirect_pc", rows[mis_row].target, last_redirect);
        compare("mispredict flush count", 1, flush_cnt);
        compare("mispredict pending retires", 0, exp_q.size());
        compare("store release count", 1, store_cnt);
        compare("mispredict alloc_tag", 0, alloc_tag);
        compare("mispredict full", 0, full);

        test_name = "full";
        for (int i = 0; i < rob_depth; i++) begin
            req.op         = op_alu;
            req.rd         = reg_name_t'(i + 10);
            req.pred_taken = 1'b0;
            alloc_one(req, rob_tag_t'(i));
        end
        // one request too many
        alloc_one(req, rob_tag_t'(0));
        compare("full after 16", 1, full);
        alloc_stop();
        @(negedge clk);
        compare("full after extra request", 1, full);
        compare("full alloc_tag", 0, alloc_tag);

        c.rd   = reg_name_t'(10);
        c.data = 32'hb000_0000;
        c.tag  = rob_tag_t'(0);
        exp_q.push_back(c);
        send_result(1'b0, rob_tag_t'(0), 32'hb000_0000, 1'b0, '0);
        @(posedge clk);
        ex_en <= 1'b0;
        rdy   <= 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        compare("full during stall", 1, full);
        compare("retires during stall", 1, exp_q.size());
        @(posedge clk);
        rdy <= 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        compare("full after retire", 0, full);
        compare("full pending retires", 0, exp_q.size());

        test_name = "flush_in";
        // refill the slot freed by the retire
        alloc_one(req, rob_tag_t'(0));
        alloc_stop();
        @(negedge clk);
        compare("flush_in full before", 1, full);

        // head tag 1 is still open, so none of these can retire
        for (int t = 3; t < 6; t++) begin
            send_result(1'b0, rob_tag_t'(t), 32'hc000_0000 + t, 1'b0, '0);
        end
        result_stop();
        @(posedge clk);
        flush_in <= 1'b1;
        @(posedge clk);
        flush_in <= 1'b0;
        send_result(1'b0, rob_tag_t'(1), 32'hc000_0001, 1'b0, '0);
        result_stop();
        repeat (6) @(posedge clk);
        @(negedge clk);
        compare("flush_in full", 0, full);
        compare("flush_in alloc_tag", 0, alloc_tag);
        compare("flush_in flush count", 1, flush_cnt);

        total = errors + UUT.u_assert.assert_fails;
        $display("%0d checks, %0d check errors, %0d assertion failures",
                 checks, errors, UUT.u_assert.assert_fails);
        if (total == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
verilog/rob_pkg.sv
verilog/rob_alloc.sv
verilog/rob_entries.sv
verilog/rob_commit.sv
verilog/rob_top.sv
verif/rob_assertions.sv
verif/rob_tb.sv
